//--- verilog/axi_pkg.sv
`default_nettype none

// ====================
// AXI read constants
// ====================

package axi_pkg;

    // Response codes
    // Only OKAY is ever returned by the pattern slave
    localparam logic [1:0] resp_okay = 2'b00;

    // Burst length field
    // AXI4 allows up to 256 beats, arlen holds beats minus one
    localparam int len_width = 8;

endpackage : axi_pkg

`default_nettype wire

//--- verilog/pattern_pkg.sv
`default_nettype none

// ====================
// Pattern and CRC constants
// ====================

package pattern_pkg;

    // LFSR start state after reset
    localparam logic [31:0] lfsr_seed = 32'hDEADBEEF;

    // Tap positions counted from one, maximal length for 32 bits
    localparam int lfsr_taps [4] = '{32, 22, 2, 1};

    // CRC-32 Ethernet polynomial, normal (non-reflected) form
    localparam logic [31:0] crc_poly   = 32'h04C11DB7;
    // Register start value
    localparam logic [31:0] crc_init   = 32'hFFFFFFFF;
    // Final XOR on the reflected register
    localparam logic [31:0] crc_xorout = 32'hFFFFFFFF;

endpackage : pattern_pkg

`default_nettype wire

//--- verilog/skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 2
) (
    input  logic     aclk,
    input  logic     crc_lfsr_reset,
    // Write side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    // Read side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload,
    output logic     empty
);

    localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    // ====================
    // Storage and pointers
    // ====================

    payload_t               mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   push;
    logic                   pop;

    // Wrap at depth, which need not be a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Flags come from the registered count only
    assign in_ready    = (count != count_width'(depth));
    assign out_valid   = (count != '0);
    assign empty       = (count == '0);
    assign out_payload = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_payload;
        end
    end

    // Pointer and occupancy tracking
    always_ff @(posedge aclk) begin
        if (crc_lfsr_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : skid_buffer

`default_nettype wire

//--- verilog/axi4_slave_rd.sv
`timescale 1ns/1ps
`default_nettype none

module axi4_slave_rd #(
    parameter int id_width   = 8,
    parameter int data_width = 64,
    parameter int ar_depth   = 2,
    parameter int r_depth    = 4
) (
    input  logic                         aclk,
    input  logic                         crc_lfsr_reset,
    // AR channel
    input  logic [id_width-1:0]          s_axi_arid,
    input  logic [axi_pkg::len_width-1:0] s_axi_arlen,
    input  logic                         s_axi_arvalid,
    output logic                         s_axi_arready,
    // R channel
    output logic [id_width-1:0]          s_axi_rid,
    output logic [data_width-1:0]        s_axi_rdata,
    output logic [1:0]                   s_axi_rresp,
    output logic                         s_axi_rlast,
    output logic                         s_axi_rvalid,
    input  logic                         s_axi_rready,
    // Beat interface to the pattern source
    output logic                         beat_req,
    output logic [id_width-1:0]          beat_id,
    input  logic [data_width-1:0]        beat_data,
    // Status
    output logic                         busy
);

    // Queued request
    typedef struct packed {
        logic [id_width-1:0]           id;
        logic [axi_pkg::len_width-1:0] len;
    } ar_payload_t;

    // Queued data beat
    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [data_width-1:0] data;
        logic                  last;
    } r_payload_t;

    // ====================
    // Request queue
    // ====================

    ar_payload_t ar_in;
    ar_payload_t ar_out;
    logic        ar_out_valid;
    logic        ar_pop;
    logic        ar_empty;

    assign ar_in.id  = s_axi_arid;
    assign ar_in.len = s_axi_arlen;

    skid_buffer #(
        .payload_t (ar_payload_t),
        .depth     (ar_depth)
    ) ar_queue (
        .aclk           (aclk),
        .crc_lfsr_reset (crc_lfsr_reset),
        .in_valid       (s_axi_arvalid),
        .in_ready       (s_axi_arready),
        .in_payload     (ar_in),
        .out_valid      (ar_out_valid),
        .out_ready      (ar_pop),
        .out_payload    (ar_out),
        .empty          (ar_empty)
    );

    // ====================
    // Burst splitter
    // ====================

    logic                          active;
    logic [id_width-1:0]           cur_id;
    logic [axi_pkg::len_width-1:0] remaining;
    logic                          last_beat;
    logic                          r_room;

    // remaining counts beats after the current one
    assign last_beat = (remaining == '0);

    // One beat per cycle while the data queue can take it
    assign beat_req = active && r_room;
    assign beat_id  = cur_id;

    // Next request loads when idle or as the last beat goes out
    assign ar_pop = ar_out_valid && (!active || (beat_req && last_beat));

    always_ff @(posedge aclk) begin
        if (crc_lfsr_reset) begin
            active    <= 1'b0;
            cur_id    <= '0;
            remaining <= '0;
        end else if (ar_pop) begin
            active    <= 1'b1;
            cur_id    <= ar_out.id;
            remaining <= ar_out.len;
        end else if (beat_req) begin
            if (last_beat) begin
                active <= 1'b0;
            end else begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // ====================
    // Data queue
    // ====================

    r_payload_t r_in;
    r_payload_t r_out;
    logic       r_empty;

    // Data arrives from the pattern source in the same cycle
    assign r_in.id   = cur_id;
    assign r_in.data = beat_data;
    assign r_in.last = last_beat;

    skid_buffer #(
        .payload_t (r_payload_t),
        .depth     (r_depth)
    ) r_queue (
        .aclk           (aclk),
        .crc_lfsr_reset (crc_lfsr_reset),
        .in_valid       (beat_req),
        .in_ready       (r_room),
        .in_payload     (r_in),
        .out_valid      (s_axi_rvalid),
        .out_ready      (s_axi_rready),
        .out_payload    (r_out),
        .empty          (r_empty)
    );

    assign s_axi_rid   = r_out.id;
    assign s_axi_rdata = r_out.data;
    assign s_axi_rlast = r_out.last;
    assign s_axi_rresp = axi_pkg::resp_okay;

    // Anything queued, in flight or waiting on the master
    assign busy = !ar_empty || active || !r_empty;

endmodule : axi4_slave_rd

`default_nettype wire

//--- verilog/lfsr_fibonacci.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_fibonacci (
    input  logic        aclk,
    input  logic        crc_lfsr_reset,
    input  logic        advance,
    output logic [31:0] state
);

    // ====================
    // Feedback
    // ====================

    logic feedback;

    // XOR of the tapped bits, taps counted from one
    always_comb begin
        feedback = 1'b0;
        for (int i = 0; i < $size(pattern_pkg::lfsr_taps); i++) begin
            feedback = feedback ^ state[pattern_pkg::lfsr_taps[i] - 1];
        end
    end

    // ====================
    // State register
    // ====================

    // Shift left, new bit enters at the bottom
    always_ff @(posedge aclk) begin
        if (crc_lfsr_reset) begin
            state <= pattern_pkg::lfsr_seed;
        end else if (advance) begin
            state <= {state[30:0], feedback};
        end
    end

endmodule : lfsr_fibonacci

`default_nettype wire

//--- verilog/crc32_engine.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_engine (
    input  logic        aclk,
    input  logic        crc_lfsr_reset,
    input  logic        update,
    input  logic [31:0] word,
    output logic [31:0] crc
);

    logic [31:0] crc_reg;

    // ====================
    // Word fold
    // ====================

    // Bytes go least significant first, each byte bit-reflected
    // Reflected byte MSB first is simply word bit 0 upward
    function automatic logic [31:0] fold_word(input logic [31:0] crc_in,
                                              input logic [31:0] data);
        logic [31:0] c;
        logic        fb;
        c = crc_in;
        for (int b = 0; b < 32; b++) begin
            fb = c[31] ^ data[b];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ pattern_pkg::crc_poly;
            end
        end
        return c;
    endfunction

    // Full 32-bit bit reversal
    function automatic logic [31:0] reflect32(input logic [31:0] value);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = value[31 - i];
        end
        return r;
    endfunction

    always_ff @(posedge aclk) begin
        if (crc_lfsr_reset) begin
            crc_reg <= pattern_pkg::crc_init;
        end else if (update) begin
            crc_reg <= fold_word(crc_reg, word);
        end
    end

    // Matches the standard CRC-32 of the byte stream
    assign crc = reflect32(crc_reg) ^ pattern_pkg::crc_xorout;

endmodule : crc32_engine

`default_nettype wire

//--- verilog/axi4_slave_rd_pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

module axi4_slave_rd_pattern_gen #(
    parameter int id_width   = 8,
    parameter int data_width = 64,
    parameter int ar_depth   = 2,
    parameter int r_depth    = 4
) (
    input  logic                          aclk,
    input  logic                          crc_lfsr_reset,
    // AR channel
    input  logic [id_width-1:0]           s_axi_arid,
    input  logic [axi_pkg::len_width-1:0] s_axi_arlen,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    // R channel
    output logic [id_width-1:0]           s_axi_rid,
    output logic [data_width-1:0]         s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rlast,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready,
    // Status
    output logic                          busy,
    output logic [31:0]                   read_crc_value,
    output logic                          read_crc_valid,
    output logic [31:0]                   read_beat_count
);

    // Copies of the 32-bit word needed to cover the bus
    localparam int rep_count = (data_width + 31) / 32;

    logic                      beat_req;
    logic [data_width-1:0]     beat_data;
    logic [31:0]               lfsr_state;
    logic [rep_count*32-1:0]   rep_word;

    // ====================
    // Protocol handler
    // ====================

    axi4_slave_rd #(
        .id_width   (id_width),
        .data_width (data_width),
        .ar_depth   (ar_depth),
        .r_depth    (r_depth)
    ) axi4_slave_rd_inst (
        .aclk           (aclk),
        .crc_lfsr_reset (crc_lfsr_reset),
        .s_axi_arid     (s_axi_arid),
        .s_axi_arlen    (s_axi_arlen),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rid      (s_axi_rid),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rlast    (s_axi_rlast),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rready   (s_axi_rready),
        .beat_req       (beat_req),
        // Pattern does not depend on the request ID
        .beat_id        (),
        .beat_data      (beat_data),
        .busy           (busy)
    );

    // ====================
    // Pattern and CRC
    // ====================

    // Steps once per served beat
    lfsr_fibonacci lfsr_inst (
        .aclk           (aclk),
        .crc_lfsr_reset (crc_lfsr_reset),
        .advance        (beat_req),
        .state          (lfsr_state)
    );

    // CRC covers the 32-bit word only, not the replicas
    crc32_engine crc_inst (
        .aclk           (aclk),
        .crc_lfsr_reset (crc_lfsr_reset),
        .update         (beat_req),
        .word           (lfsr_state),
        .crc            (read_crc_value)
    );

    // Replicate, then drop the excess top bits
    assign rep_word  = {rep_count{lfsr_state}};
    assign beat_data = rep_word[data_width-1:0];

    // ====================
    // Beat count and valid
    // ====================

    always_ff @(posedge aclk) begin
        if (crc_lfsr_reset) begin
            read_beat_count <= '0;
            read_crc_valid  <= 1'b0;
        end else if (beat_req) begin
            read_beat_count <= read_beat_count + 1'b1;
            // Sticky until the next reset
            read_crc_valid  <= 1'b1;
        end
    end

endmodule : axi4_slave_rd_pattern_gen

`default_nettype wire

//--- dv/pattern_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_gen_tb;

    localparam int id_width   = 8;
    localparam int data_width = 64;
    localparam int ar_depth   = 2;
    localparam int r_depth    = 4;
    localparam int max_tests  = 32;
    localparam int fields     = 5;
    // Ethernet polynomial in reflected bit order
    localparam logic [31:0] poly_refl = 32'hEDB88320;

    logic                          aclk = 1'b0;
    logic                          crc_lfsr_reset;
    logic [id_width-1:0]           s_axi_arid;
    logic [axi_pkg::len_width-1:0] s_axi_arlen;
    logic                          s_axi_arvalid;
    logic                          s_axi_arready;
    logic [id_width-1:0]           s_axi_rid;
    logic [data_width-1:0]         s_axi_rdata;
    logic [1:0]                    s_axi_rresp;
    logic                          s_axi_rlast;
    logic                          s_axi_rvalid;
    logic                          s_axi_rready;
    logic                          busy;
    logic [31:0]                   read_crc_value;
    logic                          read_crc_valid;
    logic [31:0]                   read_beat_count;

    // Five hex words per test line
    logic [31:0] tests [max_tests*fields];
    int unsigned value_errors = 0;
    int unsigned other_errors = 0;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;
    int unsigned stall_pct = 0;
    integer      seed = 32'h9e2b;

    // Reference model and outstanding bursts in issue order
    logic [31:0]                   model_lfsr;
    logic [31:0]                   model_crc;
    int unsigned                   model_beats;
    int unsigned                   beat_idx;
    logic [id_width-1:0]           pend_id [$];
    logic [axi_pkg::len_width-1:0] pend_len [$];
    // Last R sample kept for the hold check under stalls
    logic                          prev_stalled = 1'b0;
    logic [id_width-1:0]           prev_rid;
    logic [data_width-1:0]         prev_rdata;
    logic                          prev_rlast;

    axi4_slave_rd_pattern_gen #(
        .id_width   (id_width),
        .data_width (data_width),
        .ar_depth   (ar_depth),
        .r_depth    (r_depth)
    ) axi4_slave_rd_pattern_gen_inst (
        .aclk            (aclk),
        .crc_lfsr_reset  (crc_lfsr_reset),
        .s_axi_arid      (s_axi_arid),
        .s_axi_arlen     (s_axi_arlen),
        .s_axi_arvalid   (s_axi_arvalid),
        .s_axi_arready   (s_axi_arready),
        .s_axi_rid       (s_axi_rid),
        .s_axi_rdata     (s_axi_rdata),
        .s_axi_rresp     (s_axi_rresp),
        .s_axi_rlast     (s_axi_rlast),
        .s_axi_rvalid    (s_axi_rvalid),
        .s_axi_rready    (s_axi_rready),
        .busy            (busy),
        .read_crc_value  (read_crc_value),
        .read_crc_valid  (read_crc_valid),
        .read_beat_count (read_beat_count)
    );

    always #5 aclk = ~aclk;

    // ====================
    // Reference model
    // ====================

    // Left shift where taps 32 22 2 1 feed bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Table-free reflected CRC-32 taking the low byte of the word first
    function automatic logic [31:0] crc_add_word(input logic [31:0] crc_reg,
                                                 input logic [31:0] word);
        logic [31:0] c;
        c = crc_reg;
        for (int n = 0; n < 4; n++) begin
            c = c ^ {24'h0, word[8*n +: 8]};
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ poly_refl) : (c >> 1);
            end
        end
        return c;
    endfunction

    function automatic logic [data_width-1:0] replicate(input logic [31:0] w);
        logic [data_width-1:0] d;
        for (int i = 0; i < data_width; i++) begin
            d[i] = w[i % 32];
        end
        return d;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        assert (actual === expected) else begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            other_errors++;
            $display("Error: %s at %0t", what, $time);
        end
    endtask

    // One R transfer against the head burst and the model
    task automatic take_beat();
        if (pend_id.size() == 0) begin
            check_true(1'b0, "R beat arrived with no outstanding request");
        end else begin
            check_value("s_axi_rid", 64'(s_axi_rid), 64'(pend_id[0]));
            check_value("s_axi_rdata", 64'(s_axi_rdata), 64'(replicate(model_lfsr)));
            check_value("s_axi_rresp", 64'(s_axi_rresp), 64'(axi_pkg::resp_okay));
            check_value("s_axi_rlast", 64'(s_axi_rlast),
                        64'(beat_idx == 32'(pend_len[0])));
            model_crc  = crc_add_word(model_crc, model_lfsr);
            model_lfsr = lfsr_next(model_lfsr);
            model_beats++;
            if (beat_idx == 32'(pend_len[0])) begin
                void'(pend_id.pop_front());
                void'(pend_len.pop_front());
                beat_idx = 0;
            end else begin
                beat_idx++;
            end
        end
    endtask

    // ====================
    // Master processes
    // ====================

    // Holds reset and restarts the model, then checks the reset values
    task automatic pulse_reset(input int cycles);
        crc_lfsr_reset = 1'b1;
        repeat (cycles) @(posedge aclk);
        #1;
        crc_lfsr_reset = 1'b0;
        model_lfsr  = pattern_pkg::lfsr_seed;
        model_crc   = pattern_pkg::crc_init;
        model_beats = 0;
        beat_idx    = 0;
        pend_id.delete();
        pend_len.delete();
        @(negedge aclk);
        check_value("s_axi_rvalid", 64'(s_axi_rvalid), 64'd0);
        check_value("busy", 64'(busy), 64'd0);
        check_value("read_crc_valid", 64'(read_crc_valid), 64'd0);
        check_value("read_beat_count", 64'(read_beat_count), 64'd0);
        check_value("read_crc_value", 64'(read_crc_value), 64'd0);
        check_value("s_axi_arready", 64'(s_axi_arready), 64'd1);
        @(posedge aclk);
        #1;
    endtask

    task automatic issue_ar(input logic [id_width-1:0] id,
                            input logic [axi_pkg::len_width-1:0] len);
        logic accepted;
        accepted      = 1'b0;
        s_axi_arid    = id;
        s_axi_arlen   = len;
        s_axi_arvalid = 1'b1;
        while (!accepted) begin
            @(negedge aclk);
            if (s_axi_arready) begin
                accepted = 1'b1;
                pend_id.push_back(id);
                pend_len.push_back(len);
            end else begin
                // Full means one burst splitting plus ar_depth waiting
                check_true(pend_id.size() >= ar_depth + 1,
                           "arready low before the request queue was full");
            end
            @(posedge aclk);
            #1;
        end
        s_axi_arvalid = 1'b0;
    endtask

    // Random stalls on rready
    initial begin
        s_axi_rready = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            s_axi_rready = ($unsigned($random(seed)) % 100) >= stall_pct;
        end
    end

    // R monitor sampled mid-cycle
    always @(negedge aclk) begin
        if (crc_lfsr_reset) begin
            prev_stalled = 1'b0;
        end else begin
            if (prev_stalled) begin
                check_true(s_axi_rvalid, "rvalid dropped while rready was low");
                check_value("s_axi_rid", 64'(s_axi_rid), 64'(prev_rid));
                check_value("s_axi_rdata", 64'(s_axi_rdata), 64'(prev_rdata));
                check_value("s_axi_rlast", 64'(s_axi_rlast), 64'(prev_rlast));
            end
            if (s_axi_rvalid && s_axi_rready) begin
                take_beat();
            end
            prev_stalled = s_axi_rvalid && !s_axi_rready;
            prev_rid     = s_axi_rid;
            prev_rdata   = s_axi_rdata;
            prev_rlast   = s_axi_rlast;
        end
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            $display("Errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ====================
    // Test sequence
    // ====================

    initial begin
        int unsigned n_tests;
        int unsigned total_beats;
        int unsigned base;
        logic [31:0] expected;
        crc_lfsr_reset = 1'b1;
        s_axi_arid     = '0;
        s_axi_arlen    = '0;
        s_axi_arvalid  = 1'b0;
        // Unused slots read as all ones, which ends the table
        for (int i = 0; i < max_tests*fields; i++) begin
            tests[i] = '1;
        end
        $readmemh("dv/pattern_gen_tests.txt", tests);
        n_tests     = 0;
        total_beats = 0;
        while (n_tests < max_tests && tests[n_tests*fields] != 32'hFFFFFFFF) begin
            if (tests[n_tests*fields] == 32'h0) begin
                total_beats = total_beats + tests[n_tests*fields+2] + 1;
            end
            n_tests++;
        end
        check_true(n_tests != 0, "test file holds no tests");
        cycle_limit = 4 * total_beats + 200;
        pulse_reset(5);
        for (int unsigned t = 0; t < n_tests; t++) begin
            base = t * fields;
            if (tests[base] == 32'h1) begin
                @(posedge aclk);
                #1;
                pulse_reset(2);
            end else begin
                stall_pct = tests[base+3];
                issue_ar(tests[base+1][id_width-1:0], tests[base+2][7:0]);
                expected = tests[base+4];
                // Zero chains the next burst without waiting
                if (expected != 0) begin
                    do @(negedge aclk); while (busy);
                    check_value("read_beat_count", 64'(read_beat_count), 64'(expected));
                    check_value("received beats", 64'(model_beats), 64'(expected));
                    check_value("read_crc_value", 64'(read_crc_value),
                                64'(model_crc ^ pattern_pkg::crc_xorout));
                    check_value("read_crc_valid", 64'(read_crc_valid), 64'(model_beats != 0));
                    check_true(pend_id.size() == 0, "bursts still outstanding after busy fell");
                    @(posedge aclk);
                    #1;
                end
            end
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : pattern_gen_tb

`default_nettype wire

//--- dv/pattern_gen_tests.txt
// Columns in hex: opcode id arlen stall_percent expected_beat_count
// Opcode 0 is a burst, 1 a reset pulse; a count of 0 chains the next burst back to back
00000000 00000001 00000000 00000000 00000001
00000000 00000002 00000000 00000000 00000002
00000000 00000003 0000000f 00000000 00000012
00000000 00000004 00000007 00000032 0000001a
00000000 00000005 000000ff 00000019 0000011a
00000000 00000006 00000000 00000032 0000011b
00000001 00000000 00000000 00000000 00000000
00000000 00000007 00000003 00000000 00000004
00000000 00000010 0000001f 00000028 00000000
00000000 00000011 0000001f 00000028 00000000
00000000 00000012 0000001f 00000028 00000000
00000000 00000013 0000001f 00000028 00000000
00000000 00000014 00000000 00000028 00000085
00000001 00000000 00000000 00000000 00000000
00000000 00000015 0000003f 0000000a 00000040

//--- filelist.f
verilog/axi_pkg.sv
verilog/pattern_pkg.sv
verilog/skid_buffer.sv
verilog/axi4_slave_rd.sv
verilog/lfsr_fibonacci.sv
verilog/crc32_engine.sv
verilog/axi4_slave_rd_pattern_gen.sv
dv/pattern_gen_tb.sv

//--- Makefile
TOP := pattern_gen_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module axi4_slave_rd_pattern_gen

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
